// ==== ray_reflect_pkg.sv ====
package ray_reflect_pkg;

  // Q2.14 signed fixed point
  typedef logic signed [15:0] fx_t;
  typedef fx_t [2:0] fx_vec3_t;
  typedef logic [3:0] mat_idx_t;

  localparam int FX_FRAC_BITS = 14;
  localparam fx_t FX_ONE = 16'h4000;
  localparam fx_t ORIGIN_EPSILON = 16'h0010;

  // Galois LFSR, taps 32 22 2 1
  localparam logic [31:0] LFSR_SEED = 32'h1ACE_B00C;
  localparam logic [31:0] LFSR_TAPS = 32'h8020_0003;
  localparam int JITTER_SHIFT = 4;

  localparam int NUM_MATERIALS = 16;
  localparam int SELECT_LATENCY = 2;
  localparam int BRANCH_LATENCY = 3;

  // Queue size doubles as the upstream credit budget
  localparam int QUEUE_DEPTH = 4;
  localparam int OUT_CREDITS_INIT = 2;

  // Full width product, arithmetic shift back, truncate
  function automatic fx_t fx_mul(fx_t a, fx_t b);
    logic signed [31:0] prod;
    prod = a * b;
    return fx_t'(prod >>> FX_FRAC_BITS);
  endfunction

  function automatic fx_vec3_t vec_add(fx_vec3_t a, fx_vec3_t b);
    fx_vec3_t sum;
    for (int i = 0; i < 3; i++) begin
      sum[i] = a[i] + b[i];
    end
    return sum;
  endfunction

  function automatic fx_vec3_t vec_scale(fx_vec3_t v, fx_t s);
    fx_vec3_t scaled;
    for (int i = 0; i < 3; i++) begin
      scaled[i] = fx_mul(v[i], s);
    end
    return scaled;
  endfunction

  // Componentwise product
  function automatic fx_vec3_t vec_mul(fx_vec3_t a, fx_vec3_t b);
    fx_vec3_t prod;
    for (int i = 0; i < 3; i++) begin
      prod[i] = fx_mul(a[i], b[i]);
    end
    return prod;
  endfunction

endpackage

// ==== delay_line.sv ====
`timescale 1ns/10ps

module delay_line #(
  parameter type T = logic,
  parameter int DEPTH = 1
) (
  input  logic clk,
  input  logic arst_n,
  input  T     in,
  output T     out
);

  T stage_q [DEPTH];

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < DEPTH; i++) begin
        stage_q[i] <= '0;
      end
    end else begin
      stage_q[0] <= in;
      for (int i = 1; i < DEPTH; i++) begin
        stage_q[i] <= stage_q[i-1];
      end
    end
  end

  assign out = stage_q[DEPTH-1];

endmodule

// ==== material_table.sv ====
`timescale 1ns/10ps

module material_table (
  input  logic                       clk,
  input  logic                       arst_n,
  input  logic                       mat_wr_en,
  input  ray_reflect_pkg::mat_idx_t  mat_wr_idx,
  input  ray_reflect_pkg::fx_vec3_t  mat_wr_color,
  input  ray_reflect_pkg::fx_vec3_t  mat_wr_spec_color,
  input  ray_reflect_pkg::fx_vec3_t  mat_wr_emit_color,
  input  ray_reflect_pkg::fx_t       mat_wr_smoothness,
  input  logic [7:0]                 mat_wr_spec_prob,
  input  ray_reflect_pkg::mat_idx_t  rd_idx,
  output ray_reflect_pkg::fx_vec3_t  rd_color,
  output ray_reflect_pkg::fx_vec3_t  rd_spec_color,
  output ray_reflect_pkg::fx_vec3_t  rd_emit_color,
  output ray_reflect_pkg::fx_t       rd_smoothness,
  output logic [7:0]                 rd_spec_prob
);
  import ray_reflect_pkg::*;

  fx_vec3_t   color_mem      [NUM_MATERIALS];
  fx_vec3_t   spec_color_mem [NUM_MATERIALS];
  fx_vec3_t   emit_color_mem [NUM_MATERIALS];
  fx_t        smoothness_mem [NUM_MATERIALS];
  logic [7:0] spec_prob_mem  [NUM_MATERIALS];

  // Table starts out all black and fully diffuse
  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      for (int i = 0; i < NUM_MATERIALS; i++) begin
        color_mem[i]      <= '0;
        spec_color_mem[i] <= '0;
        emit_color_mem[i] <= '0;
        smoothness_mem[i] <= '0;
        spec_prob_mem[i]  <= '0;
      end
    end else if (mat_wr_en) begin
      color_mem[mat_wr_idx]      <= mat_wr_color;
      spec_color_mem[mat_wr_idx] <= mat_wr_spec_color;
      emit_color_mem[mat_wr_idx] <= mat_wr_emit_color;
      smoothness_mem[mat_wr_idx] <= mat_wr_smoothness;
      spec_prob_mem[mat_wr_idx]  <= mat_wr_spec_prob;
    end
  end

  // One cycle read
  always_ff @(posedge clk) begin
    rd_color      <= color_mem[rd_idx];
    rd_spec_color <= spec_color_mem[rd_idx];
    rd_emit_color <= emit_color_mem[rd_idx];
    rd_smoothness <= smoothness_mem[rd_idx];
    rd_spec_prob  <= spec_prob_mem[rd_idx];
  end

endmodule

// ==== specular_select.sv ====
`timescale 1ns/10ps

module specular_select (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      hit_valid,
  input  ray_reflect_pkg::fx_t      smoothness,
  input  logic [7:0]                spec_prob,
  input  logic                      mat_valid,
  output ray_reflect_pkg::fx_t      spec_amt,
  output ray_reflect_pkg::fx_t      one_sub_spec_amt,
  output ray_reflect_pkg::fx_vec3_t jitter,
  output logic                      sel_valid
);
  import ray_reflect_pkg::*;

  logic [31:0] lfsr_q;
  logic [31:0] lfsr_step;
  logic [31:0] draw;
  logic        is_specular;
  fx_t         spec_pick;

  // Right shifting Galois form
  assign lfsr_step = (lfsr_q >> 1) ^ (lfsr_q[0] ? LFSR_TAPS : 32'h0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      lfsr_q <= LFSR_SEED;
    end else if (hit_valid) begin
      lfsr_q <= lfsr_step;
    end
  end

  // Draw lines up with the material read
  delay_line #(.T(logic [31:0]), .DEPTH(1)) draw_pipe (
    .clk, .arst_n, .in(lfsr_step), .out(draw)
  );
  delay_line #(.T(logic), .DEPTH(1)) valid_pipe (
    .clk, .arst_n, .in(mat_valid), .out(sel_valid)
  );

  assign is_specular = draw[7:0] < spec_prob;
  assign spec_pick = is_specular ? smoothness : '0;

  always_ff @(posedge clk) begin
    if (mat_valid) begin
      spec_amt         <= spec_pick;
      one_sub_spec_amt <= FX_ONE - spec_pick;
      // Bytes 1..3 become x, y, z jitter
      for (int i = 0; i < 3; i++) begin
        jitter[i] <= fx_t'($signed(draw[8*i+8 +: 8])) <<< JITTER_SHIFT;
      end
    end
  end

endmodule

// ==== bounce_dir_unit.sv ====
`timescale 1ns/10ps

module bounce_dir_unit (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      sel_valid,
  input  ray_reflect_pkg::fx_vec3_t ray_dir,
  input  ray_reflect_pkg::fx_vec3_t hit_normal,
  input  ray_reflect_pkg::fx_vec3_t hit_pos,
  input  ray_reflect_pkg::fx_vec3_t jitter,
  input  ray_reflect_pkg::fx_t      spec_amt,
  input  ray_reflect_pkg::fx_t      one_sub_spec_amt,
  output ray_reflect_pkg::fx_vec3_t new_dir,
  output ray_reflect_pkg::fx_vec3_t new_origin,
  output logic                      dir_valid
);
  import ray_reflect_pkg::*;

  fx_t      dot_q;
  fx_t      two_dot;
  fx_vec3_t diffuse_q;
  fx_vec3_t origin_q;
  fx_vec3_t spec_q;
  fx_vec3_t ray_dir_d1;
  fx_vec3_t normal_d1;
  fx_vec3_t diffuse_d2;
  fx_t      spec_amt_d2;
  fx_t      one_sub_d2;

  // Stage 1: dot product, diffuse sum, pushed origin
  always_ff @(posedge clk) begin
    dot_q <= fx_mul(ray_dir[0], hit_normal[0]) + fx_mul(ray_dir[1], hit_normal[1]) +
             fx_mul(ray_dir[2], hit_normal[2]);
    diffuse_q <= vec_add(hit_normal, jitter);
    origin_q  <= vec_add(hit_pos, vec_scale(hit_normal, ORIGIN_EPSILON));
  end

  delay_line #(.T(fx_vec3_t), .DEPTH(1)) ray_dir_pipe (
    .clk, .arst_n, .in(ray_dir), .out(ray_dir_d1)
  );
  delay_line #(.T(fx_vec3_t), .DEPTH(1)) normal_pipe (
    .clk, .arst_n, .in(hit_normal), .out(normal_d1)
  );

  // Stage 2: d - 2(d.n)n
  assign two_dot = dot_q + dot_q;

  always_ff @(posedge clk) begin
    for (int i = 0; i < 3; i++) begin
      spec_q[i] <= ray_dir_d1[i] - fx_mul(two_dot, normal_d1[i]);
    end
  end

  // Weights and diffuse dir wait for stage 3
  delay_line #(.T(fx_t), .DEPTH(2)) spec_amt_pipe (
    .clk, .arst_n, .in(spec_amt), .out(spec_amt_d2)
  );
  delay_line #(.T(fx_t), .DEPTH(2)) one_sub_pipe (
    .clk, .arst_n, .in(one_sub_spec_amt), .out(one_sub_d2)
  );
  delay_line #(.T(fx_vec3_t), .DEPTH(1)) diffuse_pipe (
    .clk, .arst_n, .in(diffuse_q), .out(diffuse_d2)
  );

  // Stage 3: lerp, left unnormalized
  always_ff @(posedge clk) begin
    new_dir <= vec_add(vec_scale(diffuse_d2, one_sub_d2), vec_scale(spec_q, spec_amt_d2));
  end

  // Origin is ready after stage 1
  delay_line #(.T(fx_vec3_t), .DEPTH(BRANCH_LATENCY - 1)) origin_pipe (
    .clk, .arst_n, .in(origin_q), .out(new_origin)
  );
  delay_line #(.T(logic), .DEPTH(BRANCH_LATENCY)) valid_pipe (
    .clk, .arst_n, .in(sel_valid), .out(dir_valid)
  );

endmodule

// ==== bounce_color_unit.sv ====
`timescale 1ns/10ps

module bounce_color_unit (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      sel_valid,
  input  ray_reflect_pkg::fx_vec3_t ray_color,
  input  ray_reflect_pkg::fx_vec3_t income_light,
  input  ray_reflect_pkg::fx_vec3_t mat_color,
  input  ray_reflect_pkg::fx_vec3_t mat_spec_color,
  input  ray_reflect_pkg::fx_vec3_t emit_color,
  input  ray_reflect_pkg::fx_t      spec_amt,
  input  ray_reflect_pkg::fx_t      one_sub_spec_amt,
  output ray_reflect_pkg::fx_vec3_t new_color,
  output ray_reflect_pkg::fx_vec3_t new_income_light,
  output logic                      color_valid
);
  import ray_reflect_pkg::*;

  fx_vec3_t emit_q;
  fx_vec3_t diff_col_q;
  fx_vec3_t spec_col_q;
  fx_vec3_t tint_q;
  fx_vec3_t light_q;
  fx_vec3_t income_d1;
  fx_vec3_t ray_color_d2;

  // Stage 1: emitted light and weighted material colors
  always_ff @(posedge clk) begin
    emit_q     <= vec_mul(ray_color, emit_color);
    diff_col_q <= vec_scale(mat_color, one_sub_spec_amt);
    spec_col_q <= vec_scale(mat_spec_color, spec_amt);
  end

  delay_line #(.T(fx_vec3_t), .DEPTH(1)) income_pipe (
    .clk, .arst_n, .in(income_light), .out(income_d1)
  );
  delay_line #(.T(fx_vec3_t), .DEPTH(2)) ray_color_pipe (
    .clk, .arst_n, .in(ray_color), .out(ray_color_d2)
  );

  // Stage 2: blended tint and accumulated light
  always_ff @(posedge clk) begin
    tint_q  <= vec_add(diff_col_q, spec_col_q);
    light_q <= vec_add(income_d1, emit_q);
  end

  // Stage 3
  always_ff @(posedge clk) begin
    new_color        <= vec_mul(ray_color_d2, tint_q);
    new_income_light <= light_q;
  end

  delay_line #(.T(logic), .DEPTH(BRANCH_LATENCY)) valid_pipe (
    .clk, .arst_n, .in(sel_valid), .out(color_valid)
  );

endmodule

// ==== reflect_out_queue.sv ====
`timescale 1ns/10ps

module reflect_out_queue (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      dir_valid,
  input  logic                      color_valid,
  input  ray_reflect_pkg::fx_vec3_t new_dir_in,
  input  ray_reflect_pkg::fx_vec3_t new_origin_in,
  input  ray_reflect_pkg::fx_vec3_t new_color_in,
  input  ray_reflect_pkg::fx_vec3_t new_income_light_in,
  input  logic                      out_credit,
  output logic                      out_valid,
  output ray_reflect_pkg::fx_vec3_t new_dir,
  output ray_reflect_pkg::fx_vec3_t new_origin,
  output ray_reflect_pkg::fx_vec3_t new_color,
  output ray_reflect_pkg::fx_vec3_t new_income_light,
  output logic                      hit_credit
);
  import ray_reflect_pkg::*;

  fx_vec3_t dir_mem    [QUEUE_DEPTH];
  fx_vec3_t origin_mem [QUEUE_DEPTH];
  fx_vec3_t color_mem  [QUEUE_DEPTH];
  fx_vec3_t light_mem  [QUEUE_DEPTH];

  logic [$clog2(QUEUE_DEPTH)-1:0] wr_ptr;
  logic [$clog2(QUEUE_DEPTH)-1:0] rd_ptr;
  logic [$clog2(QUEUE_DEPTH):0]   count;
  logic [3:0]                     credits;
  logic                           push;
  logic                           pop;

  // Both branches finish on the same cycle
  assign push = dir_valid && color_valid;
  assign pop  = (count != '0) && (credits != '0);

  always_ff @(posedge clk or negedge arst_n) begin
    if (!arst_n) begin
      wr_ptr     <= '0;
      rd_ptr     <= '0;
      count      <= '0;
      credits    <= 4'(OUT_CREDITS_INIT);
      out_valid  <= 1'b0;
      hit_credit <= 1'b0;
    end else begin
      if (push) begin
        wr_ptr <= wr_ptr + 1'b1;
      end
      if (pop) begin
        rd_ptr <= rd_ptr + 1'b1;
      end
      case ({push, pop})
        2'b10:   count <= count + 1'b1;
        2'b01:   count <= count - 1'b1;
        default: ;
      endcase
      // Downstream credits, one spent per result
      case ({out_credit, pop})
        2'b10:   credits <= credits + 1'b1;
        2'b01:   credits <= credits - 1'b1;
        default: ;
      endcase
      out_valid  <= pop;
      hit_credit <= pop;
    end
  end

  always_ff @(posedge clk) begin
    if (push) begin
      dir_mem[wr_ptr]    <= new_dir_in;
      origin_mem[wr_ptr] <= new_origin_in;
      color_mem[wr_ptr]  <= new_color_in;
      light_mem[wr_ptr]  <= new_income_light_in;
    end
    if (pop) begin
      new_dir          <= dir_mem[rd_ptr];
      new_origin       <= origin_mem[rd_ptr];
      new_color        <= color_mem[rd_ptr];
      new_income_light <= light_mem[rd_ptr];
    end
  end

endmodule

// ==== ray_reflector_top.sv ====
`timescale 1ns/10ps

module ray_reflector_top (
  input  logic                      clk,
  input  logic                      arst_n,
  input  logic                      hit_valid,
  input  ray_reflect_pkg::fx_vec3_t ray_dir,
  input  ray_reflect_pkg::fx_vec3_t ray_color,
  input  ray_reflect_pkg::fx_vec3_t income_light,
  input  ray_reflect_pkg::fx_vec3_t hit_pos,
  input  ray_reflect_pkg::fx_vec3_t hit_normal,
  input  ray_reflect_pkg::mat_idx_t hit_mat_idx,
  output logic                      hit_credit,
  input  logic                      mat_wr_en,
  input  ray_reflect_pkg::mat_idx_t mat_wr_idx,
  input  ray_reflect_pkg::fx_vec3_t mat_wr_color,
  input  ray_reflect_pkg::fx_vec3_t mat_wr_spec_color,
  input  ray_reflect_pkg::fx_vec3_t mat_wr_emit_color,
  input  ray_reflect_pkg::fx_t      mat_wr_smoothness,
  input  logic [7:0]                mat_wr_spec_prob,
  output logic                      out_valid,
  output ray_reflect_pkg::fx_vec3_t new_dir,
  output ray_reflect_pkg::fx_vec3_t new_origin,
  output ray_reflect_pkg::fx_vec3_t new_color,
  output ray_reflect_pkg::fx_vec3_t new_income_light,
  input  logic                      out_credit
);
  import ray_reflect_pkg::*;

  fx_vec3_t   rd_color, rd_spec_color, rd_emit_color;
  fx_t        rd_smoothness;
  logic [7:0] rd_spec_prob;
  logic       mat_valid, sel_valid, dir_valid, color_valid;
  fx_t        spec_amt, one_sub_spec_amt;
  fx_vec3_t   jitter;
  fx_vec3_t   ray_dir_d, ray_color_d, income_light_d, hit_pos_d, hit_normal_d;
  fx_vec3_t   mat_color_d, mat_spec_color_d, emit_color_d;
  fx_vec3_t   dir_out, origin_out, color_out, light_out;

  material_table mat_table (
    .clk, .arst_n, .mat_wr_en, .mat_wr_idx, .mat_wr_color, .mat_wr_spec_color,
    .mat_wr_emit_color, .mat_wr_smoothness, .mat_wr_spec_prob, .rd_idx(hit_mat_idx),
    .rd_color, .rd_spec_color, .rd_emit_color, .rd_smoothness, .rd_spec_prob
  );

  delay_line #(.T(logic), .DEPTH(SELECT_LATENCY - 1)) mat_valid_pipe (
    .clk, .arst_n, .in(hit_valid), .out(mat_valid)
  );

  specular_select spec_sel (
    .clk, .arst_n, .hit_valid, .smoothness(rd_smoothness), .spec_prob(rd_spec_prob),
    .mat_valid, .spec_amt, .one_sub_spec_amt, .jitter, .sel_valid
  );

  // Hit vectors ride beside the material read and selector
  delay_line #(.T(fx_vec3_t), .DEPTH(SELECT_LATENCY)) ray_dir_pipe (
    .clk, .arst_n, .in(ray_dir), .out(ray_dir_d)
  );
  delay_line #(.T(fx_vec3_t), .DEPTH(SELECT_LATENCY)) ray_color_pipe (
    .clk, .arst_n, .in(ray_color), .out(ray_color_d)
  );
  delay_line #(.T(fx_vec3_t), .DEPTH(SELECT_LATENCY)) income_pipe (
    .clk, .arst_n, .in(income_light), .out(income_light_d)
  );
  delay_line #(.T(fx_vec3_t), .DEPTH(SELECT_LATENCY)) hit_pos_pipe (
    .clk, .arst_n, .in(hit_pos), .out(hit_pos_d)
  );
  delay_line #(.T(fx_vec3_t), .DEPTH(SELECT_LATENCY)) normal_pipe (
    .clk, .arst_n, .in(hit_normal), .out(hit_normal_d)
  );

  // Material colors catch up with the selector stage
  delay_line #(.T(fx_vec3_t), .DEPTH(SELECT_LATENCY - 1)) mat_color_pipe (
    .clk, .arst_n, .in(rd_color), .out(mat_color_d)
  );
  delay_line #(.T(fx_vec3_t), .DEPTH(SELECT_LATENCY - 1)) spec_color_pipe (
    .clk, .arst_n, .in(rd_spec_color), .out(mat_spec_color_d)
  );
  delay_line #(.T(fx_vec3_t), .DEPTH(SELECT_LATENCY - 1)) emit_color_pipe (
    .clk, .arst_n, .in(rd_emit_color), .out(emit_color_d)
  );

  bounce_dir_unit dir_unit (
    .clk, .arst_n, .sel_valid, .ray_dir(ray_dir_d), .hit_normal(hit_normal_d),
    .hit_pos(hit_pos_d), .jitter, .spec_amt, .one_sub_spec_amt,
    .new_dir(dir_out), .new_origin(origin_out), .dir_valid
  );

  bounce_color_unit color_unit (
    .clk, .arst_n, .sel_valid, .ray_color(ray_color_d), .income_light(income_light_d),
    .mat_color(mat_color_d), .mat_spec_color(mat_spec_color_d), .emit_color(emit_color_d),
    .spec_amt, .one_sub_spec_amt, .new_color(color_out), .new_income_light(light_out),
    .color_valid
  );

  reflect_out_queue out_queue (
    .clk, .arst_n, .dir_valid, .color_valid, .new_dir_in(dir_out),
    .new_origin_in(origin_out), .new_color_in(color_out), .new_income_light_in(light_out),
    .out_credit, .out_valid, .new_dir, .new_origin, .new_color, .new_income_light,
    .hit_credit
  );

endmodule

// ==== tb_ray_reflector.sv ====
`timescale 1ns/10ps

module tb_ray_reflector;
  import ray_reflect_pkg::*;

  localparam int CLK_PERIOD = 100;
  localparam int CYCLES_PER_HIT = 40;
  localparam int BASE_CYCLES = 200;
  localparam int EXPECTED_LATENCY = 6;

  logic       clk;
  logic       arst_n;
  logic       hit_valid;
  logic       hit_credit;
  logic       mat_wr_en;
  logic       out_valid;
  logic       out_credit;
  fx_vec3_t   ray_dir, ray_color, income_light, hit_pos, hit_normal;
  mat_idx_t   hit_mat_idx, mat_wr_idx;
  fx_vec3_t   mat_wr_color, mat_wr_spec_color, mat_wr_emit_color;
  fx_t        mat_wr_smoothness;
  logic [7:0] mat_wr_spec_prob;
  fx_vec3_t   new_dir, new_origin, new_color, new_income_light;

  int cycle = 0;
  int cycle_limit = BASE_CYCLES;
  int up_credits = QUEUE_DEPTH;
  int hit_count = 0;
  int out_count = 0;
  int pending_credits = 0;
  bit hold_credits = 1'b0;
  bit check_latency_next = 1'b0;
  int fd;
  string hit_name;
  logic [15:0] field [28];

  // Expected results in hit order
  string    exp_name [$];
  fx_vec3_t exp_dir [$];
  fx_vec3_t exp_origin [$];
  fx_vec3_t exp_color [$];
  fx_vec3_t exp_light [$];
  int       issue_cycle [$];
  bit       lat_check [$];

  ray_reflector_top i_dut (.*);

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  function automatic fx_vec3_t make_vec(logic [15:0] x, logic [15:0] y, logic [15:0] z);
    fx_vec3_t v;
    v[0] = x;
    v[1] = y;
    v[2] = z;
    return v;
  endfunction

  task automatic stop_with_error(input string msg);
    $display("ERROR: %s", msg);
    $display("Simulation FAILED");
    $fatal(1, "run aborted");
  endtask

  task automatic check_value(input string name, input logic [47:0] expected,
                             input logic [47:0] actual);
    if (actual !== expected) begin
      $display("FAIL %s expected %h actual %h", name, expected, actual);
      $display("Simulation FAILED");
      $fatal(1, "value mismatch");
    end
  endtask

  always @(posedge clk) begin
    cycle = cycle + 1;
    if (cycle > cycle_limit) begin
      stop_with_error("timeout, outputs stopped arriving");
    end
  end

  // Downstream side checks results and hands credits back
  always @(negedge clk) begin
    if (arst_n) begin
      out_credit = 1'b0;
      if (hit_credit) begin
        up_credits++;
      end
      if (out_valid) begin
        if (exp_name.size() == 0) begin
          stop_with_error("out_valid rose with no result pending");
        end
        check_value({exp_name[0], ".dir"}, exp_dir[0], new_dir);
        check_value({exp_name[0], ".origin"}, exp_origin[0], new_origin);
        check_value({exp_name[0], ".color"}, exp_color[0], new_color);
        check_value({exp_name[0], ".light"}, exp_light[0], new_income_light);
        check_value({exp_name[0], ".hit_credit"}, 48'(1'b1), 48'(hit_credit));
        if (lat_check[0]) begin
          check_value({exp_name[0], ".latency"}, 48'(EXPECTED_LATENCY),
                      48'(cycle - issue_cycle[0]));
        end
        void'(exp_name.pop_front());
        void'(exp_dir.pop_front());
        void'(exp_origin.pop_front());
        void'(exp_color.pop_front());
        void'(exp_light.pop_front());
        void'(issue_cycle.pop_front());
        void'(lat_check.pop_front());
        out_count++;
        if (hold_credits) begin
          pending_credits++;
        end else begin
          out_credit = 1'b1;
        end
      end else begin
        check_value("idle.hit_credit", 48'(1'b0), 48'(hit_credit));
        if (!hold_credits && pending_credits > 0) begin
          pending_credits--;
          out_credit = 1'b1;
        end
      end
    end
  end

  task automatic read_fields(input int start, input int n);
    int r;
    for (int i = 0; i < n; i++) begin
      r = $fscanf(fd, "%h", field[start + i]);
      if (r != 1) begin
        stop_with_error("malformed line in reflect_input.txt");
      end
    end
  endtask

  task automatic wait_drain();
    while (out_count != hit_count) begin
      @(negedge clk);
    end
  endtask

  // Loads only with nothing in flight
  task automatic load_material();
    wait_drain();
    mat_wr_idx = field[0][3:0];
    mat_wr_color = make_vec(field[1], field[2], field[3]);
    mat_wr_spec_color = make_vec(field[4], field[5], field[6]);
    mat_wr_emit_color = make_vec(field[7], field[8], field[9]);
    mat_wr_smoothness = field[10];
    mat_wr_spec_prob = field[11][7:0];
    mat_wr_en = 1'b1;
    @(negedge clk);
    mat_wr_en = 1'b0;
  endtask

  task automatic send_hit();
    while (up_credits == 0) begin
      @(negedge clk);
    end
    exp_name.push_back(hit_name);
    exp_dir.push_back(make_vec(field[16], field[17], field[18]));
    exp_origin.push_back(make_vec(field[19], field[20], field[21]));
    exp_color.push_back(make_vec(field[22], field[23], field[24]));
    exp_light.push_back(make_vec(field[25], field[26], field[27]));
    issue_cycle.push_back(cycle + 1);
    lat_check.push_back(check_latency_next);
    check_latency_next = 1'b0;
    hit_mat_idx = field[0][3:0];
    ray_dir = make_vec(field[1], field[2], field[3]);
    ray_color = make_vec(field[4], field[5], field[6]);
    income_light = make_vec(field[7], field[8], field[9]);
    hit_pos = make_vec(field[10], field[11], field[12]);
    hit_normal = make_vec(field[13], field[14], field[15]);
    hit_valid = 1'b1;
    up_credits--;
    hit_count++;
    @(negedge clk);
    hit_valid = 1'b0;
  endtask

  initial begin
    string tok;
    string rest;
    int r;
    int hits_in_file;
    arst_n = 1'b0;
    hit_valid = 1'b0;
    out_credit = 1'b0;
    mat_wr_en = 1'b0;
    hit_mat_idx = '0;
    mat_wr_idx = '0;
    ray_dir = '0;
    ray_color = '0;
    income_light = '0;
    hit_pos = '0;
    hit_normal = '0;
    mat_wr_color = '0;
    mat_wr_spec_color = '0;
    mat_wr_emit_color = '0;
    mat_wr_smoothness = '0;
    mat_wr_spec_prob = '0;
    // First pass sizes the timeout
    hits_in_file = 0;
    fd = $fopen("reflect_input.txt", "r");
    if (fd == 0) begin
      stop_with_error("cannot open reflect_input.txt");
    end
    while ($fscanf(fd, "%s", tok) == 1) begin
      if (tok == "#") begin
        r = $fgets(rest, fd);
      end else if (tok == "H") begin
        hits_in_file++;
      end
    end
    $fclose(fd);
    cycle_limit = CYCLES_PER_HIT * hits_in_file + BASE_CYCLES;
    repeat (3) @(posedge clk);
    @(negedge clk);
    arst_n = 1'b1;
    fd = $fopen("reflect_input.txt", "r");
    while ($fscanf(fd, "%s", tok) == 1) begin
      if (tok == "#") begin
        r = $fgets(rest, fd);
      end else if (tok == "M") begin
        read_fields(0, 12);
        load_material();
      end else if (tok == "H") begin
        r = $fscanf(fd, "%s", hit_name);
        read_fields(0, 16);
        r = $fscanf(fd, "%s", tok);
        if (tok != "E") begin
          stop_with_error("hit line without its expected line");
        end
        read_fields(16, 12);
        send_hit();
      end else if (tok == "L") begin
        wait_drain();
        check_latency_next = 1'b1;
      end else if (tok == "B") begin
        read_fields(0, 1);
        if (field[0] != '0) begin
          wait_drain();
        end
        hold_credits = (field[0] != '0);
      end else if (tok == "S") begin
        read_fields(0, 2);
        repeat (field[0]) @(negedge clk);
        check_value("settle.outputs", 48'(field[1]), 48'(out_count));
      end else begin
        stop_with_error($sformatf("unknown directive %s in reflect_input.txt", tok));
      end
    end
    $fclose(fd);
    wait_drain();
    @(negedge clk);
    $display("Simulation PASSED");
    $finish;
  end

endmodule

// ==== reflect_input.txt ====
# M idx color.xyz spec_color.xyz emit_color.xyz smoothness spec_prob
# H name idx ray_dir.xyz ray_color.xyz income.xyz hit_pos.xyz normal.xyz
# E new_dir.xyz new_origin.xyz new_color.xyz new_income_light.xyz
# L latency check on next hit, B 1 or 0 hold or release out_credit, S cycles outputs
M 0 2000 3000 1000 0000 0000 0000 0000 0000 0000 0000 00
M 1 1000 1000 1000 4000 3000 2000 0000 0000 0000 4000 ff
M 2 2000 2000 2000 4000 4000 4000 4000 2000 1000 2000 ff
L
H diff_a 0 2000 e000 0000 4000 4000 4000 0100 0200 0300 1000 0000 2000 0000 4000 0000
E 0580 4670 00d0 1000 0010 2000 2000 3000 1000 0100 0200 0300
H diff_b 0 0000 0000 c000 2000 4000 2000 0000 0000 0000 f000 0800 0400 0000 0000 4000
E fac0 fb30 4060 f000 0800 0410 1000 3000 0800 0000 0000 0000
H mirror_a 1 2000 e000 0000 4000 2000 4000 0010 0020 0030 0000 1000 0000 0000 4000 0000
E 2000 2000 0000 0000 1010 0000 4000 1800 2000 0010 0020 0030
H gloss_a 2 c000 0000 0000 4000 4000 4000 0100 0100 0100 0000 0000 0000 4000 0000 0000
E 3f58 fde0 0208 0010 0000 0000 3000 3000 3000 4100 2100 1100
B 1
H bp_a 0 0000 c000 0000 4000 4000 4000 0000 0000 0000 0100 0200 0300 0000 4000 0000
E 0750 3fe0 fa00 0100 0210 0300 2000 3000 1000 0000 0000 0000
H bp_b 1 1000 2000 e000 4000 4000 4000 0001 0002 0003 0000 0000 0000 0000 0000 4000
E 1000 2000 2000 0000 0000 0010 4000 3000 2000 0001 0002 0003
H bp_c 0 4000 0000 0000 4000 4000 4000 0000 0000 0000 2000 2000 2000 c000 0000 0000
E b9d0 02f0 0680 1ff0 2000 2000 2000 3000 1000 0000 0000 0000
H bp_d 2 0000 c000 0000 2000 2000 2000 0000 0000 0000 0000 0000 0000 0000 4000 0000
E fe70 41b8 fda0 0000 0010 0000 1800 1800 1800 2000 1000 0800
S 40 6
B 0
M 0 4000 0800 2000 0000 0000 0000 0000 0000 4000 0000 00
H rew_a 0 0000 c000 0000 4000 4000 2000 0100 0100 0100 0000 0000 0000 0000 4000 0000
E fe70 43b0 fda0 0000 0010 0000 4000 0800 1000 0100 0100 2100
H rew_b 0 0000 0000 0000 4000 4000 4000 0000 0000 0000 0400 0400 0400 0000 0000 4000
E ff30 01d0 46d0 0400 0400 0410 4000 0800 2000 0000 0000 4000

// ==== ray_reflector.f ====
ray_reflect_pkg.sv
delay_line.sv
material_table.sv
specular_select.sv
bounce_dir_unit.sv
bounce_color_unit.sv
reflect_out_queue.sv
ray_reflector_top.sv
tb_ray_reflector.sv

// ==== Makefile ====
# Verilator build for the ray reflector testbench

VERILATOR ?= verilator
TOP       ?= tb_ray_reflector
FILELIST  ?= ray_reflector.f
BUILD_DIR ?= obj_dir
VFLAGS    ?= --binary --timing -j 0

SIM_BIN = $(BUILD_DIR)/V$(TOP)

.PHONY: all compile run clean

all: run

compile:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: compile
	./$(SIM_BIN)

clean:
	rm -rf $(BUILD_DIR)
